//--- dv/dcache_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_chk (
    input wire        clk,
    input wire        rst_n,
    input wire        req_valid,
    input wire        req_ready,
    input wire        req_write,
    input wire        resp_valid,
    input wire        mem_req,
    input wire        mem_wr,
    input wire [31:0] mem_addr,
    input wire [31:0] mem_wdata,
    input wire [3:0]  mem_wstrb,
    input wire        mem_addr_ok,
    input wire [1:0]  hit_way
);

    int         fail_count = 0;
    logic [1:0] pending;

    // accepted requests still waiting for a response
    always @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= pending + 2'(req_valid && req_ready) - 2'(resp_valid);
        end
    end

    ////////////////////
    // memory port
    ////////////////////

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_addr_ok |=>
            mem_req && $stable({mem_wr, mem_addr, mem_wdata, mem_wstrb}))
        else begin
            $error("mem request dropped or changed before addr-ok");
            fail_count++;
        end

    ////////////////////
    // pipeline port
    ////////////////////

    a_resp_after_acc: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> pending != 0)
        else begin
            $error("response without an accepted request");
            fail_count++;
        end

    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> req_ready && !resp_valid && !mem_req)
        else begin
            $error("outputs not idle right after reset");
            fail_count++;
        end

    // read hit answers in the lookup cycle
    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && req_ready && !req_write) ##1 (|hit_way) |-> resp_valid)
        else begin
            $error("read hit did not respond one cycle after acceptance");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- dv/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model
    import dcache_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire  [31:0]          fill_key,
    input  wire                  mem_req,
    input  wire                  mem_wr,
    input  wire  [31:0]          mem_addr,
    input  wire  [31:0]          mem_wdata,
    input  wire  [1:0]           mem_size,
    input  wire  [3:0]           mem_wstrb,
    output logic                 mem_addr_ok,
    output logic                 mem_data_ok,
    output logic [line_bits-1:0] mem_rdata
);

    // holds only the words written so far
    logic [31:0] stored [logic [29:0]];
    logic        busy;
    logic [2:0]  cnt;
    logic        cap_wr;
    logic [31:0] cap_addr;
    logic [31:0] cap_wdata;
    logic [1:0]  cap_size;
    logic [3:0]  cap_wstrb;
    logic [31:0] merged;
    line_t       line_tmp;

    function automatic logic [31:0] read_word(input logic [29:0] widx);
        if (stored.exists(widx)) begin
            return stored[widx];
        end
        return {widx, 2'b00} ^ fill_key;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
            busy        <= 1'b0;
            cnt         <= '0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            if (!busy) begin
                // random wait before addr-ok
                if (mem_req && !mem_addr_ok) begin
                    if (cnt == 0) begin
                        mem_addr_ok <= 1'b1;
                        busy        <= 1'b1;
                        cap_wr      <= mem_wr;
                        cap_addr    <= mem_addr;
                        cap_wdata   <= mem_wdata;
                        cap_size    <= mem_size;
                        cap_wstrb   <= mem_wstrb;
                        cnt         <= 3'($urandom % 4);
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
            end else if (cnt == 0) begin
                mem_data_ok <= 1'b1;
                busy        <= 1'b0;
                cnt         <= 3'($urandom % 3);
                if (cap_wr) begin
                    merged = read_word(cap_addr[31:2]);
                    // only word-sized writes change memory
                    for (int b = 0; b < 4; b++) begin
                        if (cap_wstrb[b] && cap_size == mem_size_word) begin
                            merged[8*b +: 8] = cap_wdata[8*b +: 8];
                        end
                    end
                    stored[cap_addr[31:2]] = merged;
                end else begin
                    for (int w = 0; w < 4; w++) begin
                        line_tmp.words[w] = read_word({cap_addr[31:4], 2'(w)});
                    end
                    mem_rdata <= line_tmp;
                end
            end else begin
                cnt <= cnt - 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    localparam int          period     = 100;
    localparam logic [31:0] fill_key   = 32'h5a3c_96e1;
    // about 70 requests, each at most ~10 cycles of memory delay
    localparam int          timeout_ns = 70 * 12 * period + 40 * period;
    localparam logic [31:0] addr_a     = 32'h0000_1040;
    localparam logic [31:0] addr_b     = 32'h0000_2040;
    localparam logic [31:0] addr_c     = 32'h0000_3040;
    localparam logic [31:0] addr_d     = 32'h0000_5084;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    logic                 req_write;
    logic [31:0]          req_addr;
    logic [31:0]          req_wdata;
    logic [3:0]           req_wstrb;
    logic                 req_ready;
    logic                 resp_valid;
    logic [31:0]          resp_rdata;
    logic                 mem_req;
    logic                 mem_wr;
    logic [31:0]          mem_addr;
    logic [31:0]          mem_wdata;
    logic [1:0]           mem_size;
    logic [3:0]           mem_wstrb;
    logic                 mem_addr_ok;
    logic                 mem_data_ok;
    logic [line_bits-1:0] mem_rdata;

    int          errors = 0;
    int          reads = 0;
    int          writes = 0;
    int          accept_count = 0;
    int          resp_count = 0;
    int          edges_waited;
    int          base;
    string       cur_name;
    logic [32:0] exp_q [$];
    logic [32:0] exp_e;
    logic [69:0] wr_exp;
    logic [31:0] shadow [logic [29:0]];
    logic [31:0] sh_word;

    dcache u_dut (.*);

    dcache_mem_model u_mem (.fill_key(fill_key), .*);

    bind dcache dcache_chk u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    function automatic logic [31:0] shadow_word(input logic [29:0] widx);
        if (shadow.exists(widx)) begin
            return shadow[widx];
        end
        return {widx, 2'b00} ^ fill_key;
    endfunction

    //////////////////////
    // monitor and reference model
    //////////////////////

    always @(posedge clk) begin
        if (rst_n) begin
            if (resp_valid) begin
                resp_count++;
                if (exp_q.size() == 0) begin
                    $display("response arrived with no request outstanding (%s)", cur_name);
                    errors++;
                end else begin
                    exp_e = exp_q.pop_front();
                    if (exp_e[32]) begin
                        assert (resp_rdata == exp_e[31:0]) else begin
                            $display("FAILED %s: expected %h, actual %h",
                                     cur_name, exp_e[31:0], resp_rdata);
                            errors++;
                        end
                    end
                end
            end
            if (req_valid && req_ready) begin
                accept_count++;
                sh_word = shadow_word(req_addr[31:2]);
                if (req_write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_wstrb[b]) begin
                            sh_word[8*b +: 8] = req_wdata[8*b +: 8];
                        end
                    end
                    shadow[req_addr[31:2]] = sh_word;
                    wr_exp = {req_addr, req_wdata, req_wstrb, mem_size_word};
                    exp_q.push_back({1'b0, 32'h0});
                end else begin
                    exp_q.push_back({1'b1, sh_word});
                end
            end
            if (mem_req && mem_addr_ok) begin
                if (mem_wr) begin
                    writes++;
                    assert ({mem_addr, mem_wdata, mem_wstrb, mem_size} == wr_exp) else begin
                        $display("FAILED %s mem write: expected %h, actual %h", cur_name,
                                 wr_exp, {mem_addr, mem_wdata, mem_wstrb, mem_size});
                        errors++;
                    end
                end else begin
                    reads++;
                    assert (mem_addr[3:0] == 4'h0 && mem_wstrb == 4'h0) else begin
                        $display("line read at %h is not aligned or has strobes (%s)",
                                 mem_addr, cur_name);
                        errors++;
                    end
                end
            end
        end
    end

    //////////////////////
    // request tasks
    //////////////////////

    task automatic issue(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
        req_valid    <= 1'b1;
        req_write    <= wr;
        req_addr     <= addr;
        req_wdata    <= data;
        req_wstrb    <= strb;
        edges_waited = 0;
        do begin
            @(posedge clk);
            edges_waited++;
        end while (!req_ready);
        req_valid <= 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (resp_count != accept_count || req_valid);
        @(posedge clk);
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic read_check(input string name, input logic [31:0] addr, input int n_reads);
        cur_name = name;
        base = reads;
        issue(1'b0, addr, 32'h0, 4'h0);
        wait_done();
        check_count({name, " mem reads"}, base + n_reads, reads);
    endtask

    task automatic write_check(input string name, input logic [31:0] addr);
        cur_name = name;
        base = writes;
        issue(1'b1, addr, $urandom, 4'($urandom % 15 + 1));
        wait_done();
        check_count({name, " mem writes"}, base + 1, writes);
    endtask

    initial begin
        #(timeout_ns);
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] addr;

        void'($urandom(32'hb1606d30));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        read_check("first_read_miss", addr_a + 32'h4, 1);
        for (int w = 0; w < 4; w++) begin
            read_check("repeat_read_hit", addr_a + 32'(4 * w), 0);
        end
        write_check("write_hit", addr_a + 32'h8);
        read_check("read_after_write_hit", addr_a + 32'h8, 0);
        write_check("write_miss", addr_d);
        read_check("read_after_write_miss", addr_d, 1);

        // A sits in way 0; B, A, C then evicts B
        read_check("fill_b", addr_b, 1);
        read_check("touch_a", addr_a, 0);
        read_check("fill_c", addr_c + 32'hc, 1);
        read_check("a_kept", addr_a + 32'h4, 0);
        read_check("b_evicted", addr_b + 32'h8, 1);

        // back to back hits, valid held high
        cur_name = "hit_burst";
        base = reads;
        for (int i = 0; i < 4; i++) begin
            issue(1'b0, (i < 2 ? addr_a : addr_b) + 32'(4 * i), 32'h0, 4'h0);
            check_count("hit_burst edges to accept", 1, edges_waited);
        end
        wait_done();
        check_count("hit_burst mem reads", base, reads);

        cur_name = "random_mix";
        for (int i = 0; i < 40; i++) begin
            addr = ((1 + $urandom % 3) << 12) | ((4 + $urandom % 2) << 4) | (($urandom % 4) << 2);
            issue(1'($urandom % 2), addr, $urandom, 4'($urandom % 15 + 1));
        end
        wait_done();

        $display("errors: testbench %0d, assertions %0d", errors, u_dut.u_chk.fail_count);
        if (errors == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache
    import dcache_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    // pipeline port
    input  wire                 req_valid,
    input  wire                 req_write,
    input  wire  [31:0]         req_addr,
    input  wire  [31:0]         req_wdata,
    input  wire  [3:0]          req_wstrb,
    output logic                req_ready,
    output logic                resp_valid,
    output logic [31:0]         resp_rdata,
    // memory port
    output logic                mem_req,
    output logic                mem_wr,
    output logic [31:0]         mem_addr,
    output logic [31:0]         mem_wdata,
    output logic [1:0]          mem_size,
    output logic [3:0]          mem_wstrb,
    input  wire                 mem_addr_ok,
    input  wire                 mem_data_ok,
    input  wire  [line_bits-1:0] mem_rdata
);

    logic                buf_load;
    logic                buf_write;
    logic [31:0]         buf_addr;
    logic [31:0]         buf_wdata;
    logic [3:0]          buf_wstrb;
    logic [tag_w-1:0]    buf_tag;
    logic [index_w-1:0]  buf_index;
    logic [offset_w-1:0] buf_offset;
    logic [index_w-1:0]  rd_index;
    logic [1:0]          hit_way;
    logic [1:0]          tag_we;
    logic [1:0]          data_we;
    logic                data_refill;
    logic                lru_touch;
    logic                lru_way;
    logic                victim_way;
    logic                sel_way;
    logic                sel_return;
    line_t               rd_line0;
    line_t               rd_line1;
    line_t               mem_line;
    line_t               ret_line;

    // arrays look up the live request, ready one cycle later
    assign rd_index = req_addr[offset_w+index_w+1:offset_w+2];
    assign mem_line = mem_rdata;

    dcache_req_buf u_req_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .buf_load   (buf_load),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wstrb  (req_wstrb),
        .buf_write  (buf_write),
        .buf_addr   (buf_addr),
        .buf_wdata  (buf_wdata),
        .buf_wstrb  (buf_wstrb),
        .buf_tag    (buf_tag),
        .buf_index  (buf_index),
        .buf_offset (buf_offset)
    );

    dcache_lru u_lru (
        .clk        (clk),
        .rst_n      (rst_n),
        .lru_index  (buf_index),
        .lru_touch  (lru_touch),
        .lru_way    (lru_way),
        .victim_way (victim_way)
    );

    dcache_tagv_array u_tagv (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_index  (rd_index),
        .cmp_tag   (buf_tag),
        .wr_index  (buf_index),
        .wr_tag    (buf_tag),
        .wr_way_en (tag_we),
        .hit_way   (hit_way)
    );

    dcache_data_array u_data (
        .clk         (clk),
        .rd_index    (rd_index),
        .wr_index    (buf_index),
        .wr_way_en   (data_we),
        .wr_refill   (data_refill),
        .refill_line (mem_line),
        .wr_offset   (buf_offset),
        .wr_word     (buf_wdata),
        .wr_strb     (buf_wstrb),
        .rd_line0    (rd_line0),
        .rd_line1    (rd_line1)
    );

    dcache_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .buf_write   (buf_write),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .req_ready   (req_ready),
        .buf_load    (buf_load),
        .resp_valid  (resp_valid),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_size    (mem_size),
        .tag_we      (tag_we),
        .data_we     (data_we),
        .data_refill (data_refill),
        .lru_touch   (lru_touch),
        .lru_way     (lru_way),
        .sel_way     (sel_way),
        .sel_return  (sel_return)
    );

    ////////////////////
    // returned word
    ////////////////////

    // miss answers straight from the memory line
    assign ret_line   = sel_return ? mem_line : (sel_way ? rd_line1 : rd_line0);
    assign resp_rdata = ret_line.words[buf_offset];

    ////////////////////
    // memory request
    ////////////////////

    // line reads are aligned, writes keep the word address
    assign mem_addr  = buf_write ? buf_addr
                                 : {buf_addr[31:offset_w+2], {(offset_w+2){1'b0}}};
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_write ? buf_wstrb : 4'b0000;

endmodule

`default_nettype wire

//--- logic/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array
    import dcache_pkg::*;
(
    input  wire                 clk,
    input  wire  [index_w-1:0]  rd_index,
    input  wire  [index_w-1:0]  wr_index,
    input  wire  [1:0]          wr_way_en,
    input  wire                 wr_refill,
    input  wire line_t          refill_line,
    input  wire  [offset_w-1:0] wr_offset,
    input  wire  [31:0]         wr_word,
    input  wire  [3:0]          wr_strb,
    output line_t               rd_line0,
    output line_t               rd_line1
);

    // line storage, way major
    line_t lines [2][num_sets];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wr_way_en[w]) begin
                if (wr_refill) begin
                    // whole line from memory
                    lines[w][wr_index] <= refill_line;
                end else begin
                    // only the strobed bytes of one word
                    for (int b = 0; b < 4; b++) begin
                        if (wr_strb[b]) begin
                            lines[w][wr_index].bytes[4*wr_offset+b] <= wr_word[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // registered, lines up with the buffered request
    always_ff @(posedge clk) begin
        rd_line0 <= lines[0][rd_index];
        rd_line1 <= lines[1][rd_index];
    end

endmodule

`default_nettype wire

//--- logic/dcache_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_fsm
    import dcache_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        req_valid,
    input  wire        buf_write,
    input  wire  [1:0] hit_way,
    input  wire        victim_way,
    input  wire        mem_addr_ok,
    input  wire        mem_data_ok,
    output logic       req_ready,
    output logic       buf_load,
    output logic       resp_valid,
    output logic       mem_req,
    output logic       mem_wr,
    output logic [1:0] mem_size,
    output logic [1:0] tag_we,
    output logic [1:0] data_we,
    output logic       data_refill,
    output logic       lru_touch,
    output logic       lru_way,
    output logic       sel_way,
    output logic       sel_return
);

    logic [state_w-1:0] state;
    logic [state_w-1:0] state_nxt;
    logic               hit;
    logic [1:0]         victim_oh;

    assign hit       = |hit_way;
    assign victim_oh = victim_way ? 2'b10 : 2'b01;

    // every access to memory is one word or one line
    assign mem_size = mem_size_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt   = state;
        req_ready   = 1'b0;
        buf_load    = 1'b0;
        resp_valid  = 1'b0;
        mem_req     = 1'b0;
        mem_wr      = 1'b0;
        tag_we      = 2'b00;
        data_we     = 2'b00;
        data_refill = 1'b0;
        lru_touch   = 1'b0;
        lru_way     = 1'b0;
        sel_way     = 1'b0;
        sel_return  = 1'b0;
        case (state)
            st_idle: begin
                req_ready = 1'b1;
                if (req_valid) begin
                    buf_load  = 1'b1;
                    state_nxt = st_lookup;
                end
            end
            // array outputs belong to the buffered request here
            st_lookup: begin
                if (buf_write) begin
                    // merge into the hit way, no allocate on miss
                    if (hit) begin
                        data_we   = hit_way;
                        lru_touch = 1'b1;
                        lru_way   = hit_way[1];
                    end
                    state_nxt = st_wr_req;
                end else if (hit) begin
                    resp_valid = 1'b1;
                    req_ready  = 1'b1;
                    sel_way    = hit_way[1];
                    lru_touch  = 1'b1;
                    lru_way    = hit_way[1];
                    // next request can go straight into lookup
                    if (req_valid) begin
                        buf_load  = 1'b1;
                        state_nxt = st_lookup;
                    end else begin
                        state_nxt = st_idle;
                    end
                end else begin
                    state_nxt = st_miss_req;
                end
            end
            st_miss_req: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    state_nxt = st_miss_wt;
                end
            end
            st_miss_wt: begin
                if (mem_data_ok) begin
                    // answer from the bus and refill the victim together
                    resp_valid  = 1'b1;
                    sel_return  = 1'b1;
                    data_we     = victim_oh;
                    tag_we      = victim_oh;
                    data_refill = 1'b1;
                    lru_touch   = 1'b1;
                    lru_way     = victim_way;
                    state_nxt   = st_idle;
                end
            end
            st_wr_req: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (mem_addr_ok) begin
                    state_nxt = st_wr_wt;
                end
            end
            st_wr_wt: begin
                if (mem_data_ok) begin
                    resp_valid = 1'b1;
                    state_nxt  = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/dcache_lru.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lru
    import dcache_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire [index_w-1:0]  lru_index,
    input  wire                lru_touch,
    input  wire                lru_way,
    output logic               victim_way
);

    // one bit per set, names the way to evict next
    logic [num_sets-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (lru_touch) begin
            // used way becomes most recent
            lru_bits[lru_index] <= ~lru_way;
        end
    end

    // index comes from the request buffer, so this is stable per request
    assign victim_way = lru_bits[lru_index];

endmodule

`default_nettype wire

//--- logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////
    // cache geometry
    ////////////////////

    // 16 sets of two ways
    localparam int index_w = 4;
    // 4 words per line
    localparam int offset_w = 2;
    // what is left above index, offset and byte bits
    localparam int tag_w = 32 - index_w - offset_w - 2;

    localparam int num_sets = 1 << index_w;
    localparam int line_bits = 32 << offset_w;

    // memory size code for a four-byte access
    localparam logic [1:0] mem_size_word = 2'd2;

    ////////////////////
    // controller states
    ////////////////////

    localparam int state_w = 3;

    localparam logic [state_w-1:0] st_idle     = 3'd0;
    localparam logic [state_w-1:0] st_lookup   = 3'd1;
    localparam logic [state_w-1:0] st_miss_req = 3'd2;
    localparam logic [state_w-1:0] st_miss_wt  = 3'd3;
    localparam logic [state_w-1:0] st_wr_req   = 3'd4;
    localparam logic [state_w-1:0] st_wr_wt    = 3'd5;

    ////////////////////
    // line views
    ////////////////////

    // word view for read select and refill, byte view for strobe merge
    typedef union packed {
        logic [(1 << offset_w)-1:0][31:0] words;
        logic [(4 << offset_w)-1:0][7:0]  bytes;
    } line_t;

endpackage

`default_nettype wire

//--- logic/dcache_req_buf.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_req_buf
    import dcache_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 buf_load,
    input  wire                 req_write,
    input  wire  [31:0]         req_addr,
    input  wire  [31:0]         req_wdata,
    input  wire  [3:0]          req_wstrb,
    output logic                buf_write,
    output logic [31:0]         buf_addr,
    output logic [31:0]         buf_wdata,
    output logic [3:0]          buf_wstrb,
    output logic [tag_w-1:0]    buf_tag,
    output logic [index_w-1:0]  buf_index,
    output logic [offset_w-1:0] buf_offset
);

    // held from acceptance until the response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_write <= 1'b0;
            buf_addr  <= '0;
            buf_wdata <= '0;
            buf_wstrb <= '0;
        end else if (buf_load) begin
            buf_write <= req_write;
            buf_addr  <= req_addr;
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    // address fields, byte bits dropped
    assign buf_offset = buf_addr[offset_w+1:2];
    assign buf_index  = buf_addr[offset_w+index_w+1:offset_w+2];
    assign buf_tag    = buf_addr[31:offset_w+index_w+2];

endmodule

`default_nettype wire

//--- logic/dcache_tagv_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tagv_array
    import dcache_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire  [index_w-1:0] rd_index,
    input  wire  [tag_w-1:0]   cmp_tag,
    input  wire  [index_w-1:0] wr_index,
    input  wire  [tag_w-1:0]   wr_tag,
    input  wire  [1:0]         wr_way_en,
    output logic [1:0]         hit_way
);

    logic [tag_w-1:0]    tag_mem [2][num_sets];
    logic [tag_w-1:0]    rd_tag [2];
    logic [1:0][num_sets-1:0] valid_bits;
    logic [1:0]          rd_valid;

    // valid bits live in flops so they can clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits <= '0;
            rd_valid   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_way_en[w]) begin
                    valid_bits[w][wr_index] <= 1'b1;
                end
                rd_valid[w] <= valid_bits[w][rd_index];
            end
        end
    end

    // tags only on refill
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wr_way_en[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
            rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    // compare against the buffered tag
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_way[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the dcache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module dcache_tb -o dcache_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dcache_sim +verilator+error+limit+1000)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

//--- sim.f
logic/dcache_pkg.sv
logic/dcache_req_buf.sv
logic/dcache_lru.sv
logic/dcache_data_array.sv
logic/dcache_tagv_array.sv
logic/dcache_fsm.sv
logic/dcache.sv
dv/dcache_mem_model.sv
dv/dcache_chk.sv
dv/dcache_tb.sv
